//--- hdl/cpu_types_pkg.sv
//////////////////////////////////////////////////
// CPU datapath types
// Word, register and interrupt widths, memory
// operation codes and exception codes shared by
// the memory stage and the data memory
//////////////////////////////////////////////////

package cpu_types_pkg;

	typedef logic [31:0] word_t;     // Data or address word
	typedef logic [4:0]  reg_addr_t; // GPR number where 0 means no write
	typedef logic [2:0]  mem_opt_t;
	typedef logic [4:0]  exc_code_t;
	typedef logic [7:0]  int_mask_t; // One bit per interrupt line

	// Memory operation codes
	localparam mem_opt_t MEM_OPT_NONE          = 3'd0;
	localparam mem_opt_t MEM_OPT_READ          = 3'd1;
	localparam mem_opt_t MEM_OPT_WRITE         = 3'd2;
	localparam mem_opt_t MEM_OPT_READ_SPECIAL  = 3'd3; // cp0 read
	localparam mem_opt_t MEM_OPT_WRITE_SPECIAL = 3'd4; // cp0 write

	// Exception codes as written into cause
	localparam exc_code_t EC_INT  = 5'd0;
	localparam exc_code_t EC_ADEL = 5'd4;  // Address error on load
	localparam exc_code_t EC_ADES = 5'd5;  // Address error on store
	localparam exc_code_t EC_DBE  = 5'd7;  // Data bus error
	localparam exc_code_t EC_SYS  = 5'd8;
	localparam exc_code_t EC_RI   = 5'd10;
	localparam exc_code_t EC_NONE = 5'd31; // No exception pending

	// Data memory size in words
	localparam int DMEM_WORDS = 256;

endpackage

//--- hdl/cp0_pkg.sv
//////////////////////////////////////////////////
// Coprocessor 0 definitions
// Register indices, status and cause field
// positions, reset value and exception vector
//////////////////////////////////////////////////

package cp0_pkg;

	typedef logic [4:0] cp0_addr_t;

	// Register indices
	localparam cp0_addr_t CP0_BADVADDR = 5'd8;
	localparam cp0_addr_t CP0_STATUS   = 5'd12;
	localparam cp0_addr_t CP0_CAUSE    = 5'd13;
	localparam cp0_addr_t CP0_EPC      = 5'd14;

	// Status fields
	localparam int STATUS_IE     = 0; // Global interrupt enable
	localparam int STATUS_EXL    = 1; // Exception level
	localparam int STATUS_IM_LSB = 8; // IM field is bits 15:8

	// Cause fields
	localparam int CAUSE_IP_LSB  = 8;
	localparam int CAUSE_EXC_LSB = 2; // Exception code in bits 6:2

	localparam cpu_types_pkg::word_t EXC_VECTOR   = 32'h8000_0180;
	localparam cpu_types_pkg::word_t STATUS_RESET = 32'h0000_0000;

endpackage

//--- hdl/mem_bus_if.sv
//////////////////////////////////////////////////
// Data memory bus
// One four-phase request and its response between
// the memory stage and the data memory
//////////////////////////////////////////////////

`timescale 1ns/1ns

interface mem_bus_if;

	// Request fields held while req is high
	logic                     req;
	cpu_types_pkg::mem_opt_t  opt;
	cpu_types_pkg::word_t     addr;
	cpu_types_pkg::word_t     wdata;

	// Response fields valid while ack is high
	logic                     ack;
	cpu_types_pkg::word_t     rdata;
	cpu_types_pkg::exc_code_t exc_code;

	modport stage (
		output req, opt, addr, wdata,
		input  ack, rdata, exc_code
	);

	modport mem (
		input  req, opt, addr, wdata,
		output ack, rdata, exc_code
	);

endinterface

//--- hdl/stage_mem.sv
//////////////////////////////////////////////////
// Memory stage control
// Accepts one instruction from execute, resolves
// exceptions and interrupts, runs cp0 or memory
// accesses and completes the req/ack handshake
//////////////////////////////////////////////////

`timescale 1ns/1ns

module stage_mem (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ex_req,
	input  cpu_types_pkg::mem_opt_t  ex_mem_opt,
	input  cpu_types_pkg::word_t     ex_mem_addr,
	input  cpu_types_pkg::word_t     ex_mem_data,
	input  cpu_types_pkg::word_t     ex_alu_result,
	input  cpu_types_pkg::reg_addr_t ex_wb_reg,
	input  cpu_types_pkg::exc_code_t ex_exc_code,
	input  cpu_types_pkg::word_t     ex_epc,
	output logic                     ex_ack,
	output logic                     wb_valid,
	output cpu_types_pkg::reg_addr_t wb_reg_addr,
	output cpu_types_pkg::word_t     wb_reg_data,
	input  cpu_types_pkg::int_mask_t int_req,
	output cpu_types_pkg::int_mask_t int_ack,
	mem_bus_if.stage                 bus,
	input  cpu_types_pkg::word_t     status,
	output logic                     exc_valid,
	output cpu_types_pkg::exc_code_t exc_code,
	output cpu_types_pkg::int_mask_t exc_ip,
	output cpu_types_pkg::word_t     exc_epc,
	output cpu_types_pkg::word_t     exc_badvaddr,
	output logic                     cp0_wr_en,
	output cp0_pkg::cp0_addr_t       cp0_wr_addr,
	output cp0_pkg::cp0_addr_t       cp0_rd_addr,
	output cpu_types_pkg::word_t     cp0_wr_data,
	input  cpu_types_pkg::word_t     cp0_rd_data
);

	typedef enum logic [1:0] {IDLE, WAIT_MEM, RELEASE} state_t;

	state_t                   state;
	cpu_types_pkg::int_mask_t int_pending;
	logic                     int_taken;

	// Lines that are both requested and unmasked in status IM
	assign int_pending = int_req & status[cp0_pkg::STATUS_IM_LSB +: $bits(int_pending)];
	assign int_taken = (int_pending != '0) && status[cp0_pkg::STATUS_IE]
		&& !status[cp0_pkg::STATUS_EXL];

	assign cp0_rd_addr = cp0_pkg::cp0_addr_t'(ex_mem_addr); // Combinational cp0 read

	always_ff @(posedge clk) begin
		wb_valid  <= 1'b0; // Single-cycle pulses
		exc_valid <= 1'b0;
		cp0_wr_en <= 1'b0;
		int_ack   <= '0;
		if (rst) begin
			state   <= IDLE;
			ex_ack  <= 1'b0;
			bus.req <= 1'b0;
		end else begin
			case (state)
				IDLE: if (ex_req) begin
					exc_epc      <= ex_epc;
					exc_ip       <= '0;
					exc_badvaddr <= ex_mem_addr;
					wb_reg_addr  <= ex_wb_reg;
					wb_reg_data  <= ex_alu_result;
					ex_ack       <= 1'b1;
					state        <= RELEASE;
					if (ex_exc_code != cpu_types_pkg::EC_NONE) begin
						exc_valid <= 1'b1; // Forwarded exception wins
						exc_code  <= ex_exc_code;
					end else if (int_taken) begin
						exc_valid <= 1'b1;
						exc_code  <= cpu_types_pkg::EC_INT;
						exc_ip    <= int_pending;
						int_ack   <= int_pending;
					end else begin
						case (ex_mem_opt)
							cpu_types_pkg::MEM_OPT_READ,
							cpu_types_pkg::MEM_OPT_WRITE: begin
								// Completion waits for the memory
								ex_ack    <= 1'b0;
								state     <= WAIT_MEM;
								bus.req   <= 1'b1;
								bus.opt   <= ex_mem_opt;
								bus.addr  <= ex_mem_addr;
								bus.wdata <= ex_mem_data;
							end
							cpu_types_pkg::MEM_OPT_WRITE_SPECIAL: begin
								cp0_wr_en   <= 1'b1;
								cp0_wr_addr <= cp0_pkg::cp0_addr_t'(ex_mem_addr);
								cp0_wr_data <= ex_mem_data;
							end
							cpu_types_pkg::MEM_OPT_READ_SPECIAL: begin
								wb_reg_data <= cp0_rd_data;
								wb_valid    <= (ex_wb_reg != '0);
							end
							default: wb_valid <= (ex_wb_reg != '0); // Plain ALU result
						endcase
					end
				end
				WAIT_MEM: if (bus.ack) begin
					bus.req <= 1'b0;
					ex_ack  <= 1'b1;
					state   <= RELEASE;
					if (bus.exc_code != cpu_types_pkg::EC_NONE) begin
						exc_valid    <= 1'b1;
						exc_code     <= bus.exc_code;
						exc_badvaddr <= bus.addr; // Faulting address
					end else if (bus.opt == cpu_types_pkg::MEM_OPT_READ) begin
						wb_reg_data <= bus.rdata;
						wb_valid    <= (wb_reg_addr != '0);
					end
				end
				RELEASE: if (!ex_req) begin
					ex_ack <= 1'b0;
					state  <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- hdl/cp0_regs.sv
//////////////////////////////////////////////////
// Coprocessor 0 registers
// Status, cause, epc and badvaddr with software
// access and exception entry; requests the jump
// to the exception vector
//////////////////////////////////////////////////

`timescale 1ns/1ns

module cp0_regs (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     exc_valid,
	input  cpu_types_pkg::exc_code_t exc_code,
	input  cpu_types_pkg::int_mask_t exc_ip,
	input  cpu_types_pkg::word_t     exc_epc,
	input  cpu_types_pkg::word_t     exc_badvaddr,
	input  logic                     wr_en,
	input  cp0_pkg::cp0_addr_t       wr_addr,
	input  cpu_types_pkg::word_t     wr_data,
	input  cp0_pkg::cp0_addr_t       rd_addr,
	output cpu_types_pkg::word_t     rd_data,
	output cpu_types_pkg::word_t     status,
	output logic                     exc_jmp_flag,
	output cpu_types_pkg::word_t     exc_jmp_dest
);

	cpu_types_pkg::word_t cause;
	cpu_types_pkg::word_t epc;
	cpu_types_pkg::word_t badvaddr;
	cpu_types_pkg::word_t cause_entry;
	logic                 addr_exc;

	// Only address and bus errors carry a meaningful bad address
	assign addr_exc = (exc_code == cpu_types_pkg::EC_ADEL) ||
		(exc_code == cpu_types_pkg::EC_ADES) || (exc_code == cpu_types_pkg::EC_DBE);

	always_comb begin
		cause_entry = cause;
		cause_entry[cp0_pkg::CAUSE_IP_LSB +: $bits(exc_ip)]    = exc_ip;
		cause_entry[cp0_pkg::CAUSE_EXC_LSB +: $bits(exc_code)] = exc_code;
	end

	assign exc_jmp_dest = cp0_pkg::EXC_VECTOR; // Single fixed vector

	always_ff @(posedge clk) begin
		if (rst) begin
			status       <= cp0_pkg::STATUS_RESET;
			cause        <= '0;
			exc_jmp_flag <= 1'b0;
		end else begin
			exc_jmp_flag <= exc_valid;
			if (exc_valid) begin
				epc   <= exc_epc;
				cause <= cause_entry;
				status[cp0_pkg::STATUS_EXL] <= 1'b1; // Blocks further interrupts
				if (addr_exc)
					badvaddr <= exc_badvaddr;
			end else if (wr_en) begin
				case (wr_addr)
					cp0_pkg::CP0_STATUS:   status   <= wr_data;
					cp0_pkg::CP0_CAUSE:    cause    <= wr_data;
					cp0_pkg::CP0_EPC:      epc      <= wr_data;
					cp0_pkg::CP0_BADVADDR: badvaddr <= wr_data;
					default: ; // Unimplemented index
				endcase
			end
		end
	end

	always_comb begin
		case (rd_addr)
			cp0_pkg::CP0_STATUS:   rd_data = status;
			cp0_pkg::CP0_CAUSE:    rd_data = cause;
			cp0_pkg::CP0_EPC:      rd_data = epc;
			cp0_pkg::CP0_BADVADDR: rd_data = badvaddr;
			default:               rd_data = '0;
		endcase
	end

endmodule

//--- hdl/data_mem.sv
//////////////////////////////////////////////////
// Data memory
// Word array behind a four-phase handshake with
// alignment and range checks
//////////////////////////////////////////////////

`timescale 1ns/1ns

module data_mem (
	input  logic clk,
	input  logic rst,
	mem_bus_if.mem bus
);

	typedef enum logic [1:0] {IDLE, DELAY, ACCESS, HOLD} state_t;

	state_t               state;
	cpu_types_pkg::word_t mem [cpu_types_pkg::DMEM_WORDS];
	logic                 misaligned;
	logic                 out_of_range;
	logic                 access_ok;

	assign misaligned   = (bus.addr[1:0] != 2'b00);
	assign out_of_range = (bus.addr >= cpu_types_pkg::word_t'(cpu_types_pkg::DMEM_WORDS * 4));
	assign access_ok    = (state == ACCESS) && !misaligned && !out_of_range;

	// Ack rises two cycles after req is seen
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			bus.ack <= 1'b0;
		end else begin
			case (state)
				IDLE:   if (bus.req) state <= DELAY;
				DELAY:  state <= ACCESS;
				ACCESS: begin
					bus.ack <= 1'b1;
					state   <= HOLD;
					if (misaligned)
						bus.exc_code <= (bus.opt == cpu_types_pkg::MEM_OPT_WRITE) ?
							cpu_types_pkg::EC_ADES : cpu_types_pkg::EC_ADEL;
					else if (out_of_range)
						bus.exc_code <= cpu_types_pkg::EC_DBE;
					else
						bus.exc_code <= cpu_types_pkg::EC_NONE;
				end
				HOLD: if (!bus.req) begin
					bus.ack <= 1'b0;
					state   <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Storage indexed by address bits 9:2
	always_ff @(posedge clk) begin
		if (access_ok) begin
			if (bus.opt == cpu_types_pkg::MEM_OPT_WRITE)
				mem[bus.addr[2 +: $clog2(cpu_types_pkg::DMEM_WORDS)]] <= bus.wdata;
			else
				bus.rdata <= mem[bus.addr[2 +: $clog2(cpu_types_pkg::DMEM_WORDS)]];
		end
	end

endmodule

//--- hdl/mem_subsys_top.sv
//////////////////////////////////////////////////
// Memory subsystem top
// Memory stage with its cp0 register file and
// data memory
//////////////////////////////////////////////////

`timescale 1ns/1ns

module mem_subsys_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ex_req,
	input  cpu_types_pkg::mem_opt_t  ex_mem_opt,
	input  cpu_types_pkg::word_t     ex_mem_addr,
	input  cpu_types_pkg::word_t     ex_mem_data,
	input  cpu_types_pkg::word_t     ex_alu_result,
	input  cpu_types_pkg::reg_addr_t ex_wb_reg,
	input  cpu_types_pkg::exc_code_t ex_exc_code,
	input  cpu_types_pkg::word_t     ex_epc,
	output logic                     ex_ack,
	output logic                     wb_valid,
	output cpu_types_pkg::reg_addr_t wb_reg_addr,
	output cpu_types_pkg::word_t     wb_reg_data,
	output logic                     exc_jmp_flag,
	output cpu_types_pkg::word_t     exc_jmp_dest,
	input  cpu_types_pkg::int_mask_t int_req,
	output cpu_types_pkg::int_mask_t int_ack
);

	mem_bus_if bus ();

	cpu_types_pkg::word_t     status;
	logic                     exc_valid;
	cpu_types_pkg::exc_code_t exc_code;
	cpu_types_pkg::int_mask_t exc_ip;
	cpu_types_pkg::word_t     exc_epc;
	cpu_types_pkg::word_t     exc_badvaddr;
	logic                     cp0_wr_en;
	cp0_pkg::cp0_addr_t       cp0_wr_addr;
	cp0_pkg::cp0_addr_t       cp0_rd_addr;
	cpu_types_pkg::word_t     cp0_wr_data;
	cpu_types_pkg::word_t     cp0_rd_data;

	stage_mem u_stage_mem (
		.clk(clk), .rst(rst),
		.ex_req(ex_req), .ex_mem_opt(ex_mem_opt), .ex_mem_addr(ex_mem_addr),
		.ex_mem_data(ex_mem_data), .ex_alu_result(ex_alu_result),
		.ex_wb_reg(ex_wb_reg), .ex_exc_code(ex_exc_code), .ex_epc(ex_epc),
		.ex_ack(ex_ack),
		.wb_valid(wb_valid), .wb_reg_addr(wb_reg_addr), .wb_reg_data(wb_reg_data),
		.int_req(int_req), .int_ack(int_ack),
		.bus(bus.stage),
		.status(status),
		.exc_valid(exc_valid), .exc_code(exc_code), .exc_ip(exc_ip),
		.exc_epc(exc_epc), .exc_badvaddr(exc_badvaddr),
		.cp0_wr_en(cp0_wr_en), .cp0_wr_addr(cp0_wr_addr), .cp0_rd_addr(cp0_rd_addr),
		.cp0_wr_data(cp0_wr_data), .cp0_rd_data(cp0_rd_data)
	);

	cp0_regs u_cp0_regs (
		.clk(clk), .rst(rst),
		.exc_valid(exc_valid), .exc_code(exc_code), .exc_ip(exc_ip),
		.exc_epc(exc_epc), .exc_badvaddr(exc_badvaddr),
		.wr_en(cp0_wr_en), .wr_addr(cp0_wr_addr), .wr_data(cp0_wr_data),
		.rd_addr(cp0_rd_addr), .rd_data(cp0_rd_data),
		.status(status),
		.exc_jmp_flag(exc_jmp_flag), .exc_jmp_dest(exc_jmp_dest)
	);

	data_mem u_data_mem (
		.clk(clk), .rst(rst),
		.bus(bus.mem)
	);

endmodule

//--- dv/mem_subsys_chk.sv
//////////////////////////////////////////////////
// Memory subsystem protocol checker
// Handshake and exception jump assertions,
// bound to the memory subsystem top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

module mem_subsys_chk (
	input logic                     clk,
	input logic                     rst,
	input logic                     ex_req,
	input logic                     ex_ack,
	input logic                     wb_valid,
	input logic                     exc_jmp_flag,
	input cpu_types_pkg::int_mask_t int_ack
);

	int fail_count;

	initial fail_count = 0;

	// Completion only for a request seen on the previous edge
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ex_ack) |-> $past(ex_req))
		else begin
			$error("ex_ack rose while ex_req was low");
			fail_count++;
		end

	jmp_one_cycle: assert property (@(posedge clk) disable iff (rst)
		exc_jmp_flag |=> !exc_jmp_flag)
		else begin
			$error("exc_jmp_flag held for more than one cycle");
			fail_count++;
		end

	wb_or_jmp: assert property (@(posedge clk) disable iff (rst)
		!(wb_valid && exc_jmp_flag))
		else begin
			$error("wb_valid and exc_jmp_flag high together");
			fail_count++;
		end

	// Interrupt acknowledge leads the jump by exactly one cycle
	int_ack_before_jmp: assert property (@(posedge clk) disable iff (rst)
		(int_ack != '0) |=> exc_jmp_flag)
		else begin
			$error("int_ack not followed by exc_jmp_flag");
			fail_count++;
		end

endmodule

bind mem_subsys_top mem_subsys_chk u_chk (
	.clk(clk), .rst(rst),
	.ex_req(ex_req), .ex_ack(ex_ack),
	.wb_valid(wb_valid), .exc_jmp_flag(exc_jmp_flag),
	.int_ack(int_ack)
);

//--- dv/tb_mem_subsys.sv
//////////////////////////////////////////////////
// Memory subsystem testbench
// Table of instructions sent over the execute
// handshake, write-back and exception jump checks
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_mem_subsys;

	localparam int          TIMEOUT_CYCLES = 50;
	localparam logic [31:0] SEED = 32'hefb145ef;

	localparam cpu_types_pkg::mem_opt_t ALU = cpu_types_pkg::MEM_OPT_NONE;
	localparam cpu_types_pkg::mem_opt_t LD  = cpu_types_pkg::MEM_OPT_READ;
	localparam cpu_types_pkg::mem_opt_t ST  = cpu_types_pkg::MEM_OPT_WRITE;
	localparam cpu_types_pkg::mem_opt_t CRD = cpu_types_pkg::MEM_OPT_READ_SPECIAL;
	localparam cpu_types_pkg::mem_opt_t CWR = cpu_types_pkg::MEM_OPT_WRITE_SPECIAL;

	localparam cpu_types_pkg::exc_code_t NOEXC = cpu_types_pkg::EC_NONE;
	localparam cpu_types_pkg::exc_code_t SYS   = cpu_types_pkg::EC_SYS;

	localparam logic [1:0] X_WB    = 2'd0; // One write-back
	localparam logic [1:0] X_EXC   = 2'd1; // One exception jump
	localparam logic [1:0] X_QUIET = 2'd2; // Neither

	typedef struct packed {
		cpu_types_pkg::mem_opt_t   op;
		cpu_types_pkg::word_t      addr; // Memory address or cp0 index
		cpu_types_pkg::word_t      val;  // ALU result or write data
		cpu_types_pkg::reg_addr_t  rd;
		cpu_types_pkg::exc_code_t  code;
		cpu_types_pkg::word_t      epc;
		cpu_types_pkg::int_mask_t  irq;
		logic [1:0]                kind;
		cpu_types_pkg::word_t      exp_data;
		cpu_types_pkg::int_mask_t  exp_ip;
	} entry_t;

	logic                     clk;
	logic                     rst;
	logic                     ex_req;
	cpu_types_pkg::mem_opt_t  ex_mem_opt;
	cpu_types_pkg::word_t     ex_mem_addr;
	cpu_types_pkg::word_t     ex_mem_data;
	cpu_types_pkg::word_t     ex_alu_result;
	cpu_types_pkg::reg_addr_t ex_wb_reg;
	cpu_types_pkg::exc_code_t ex_exc_code;
	cpu_types_pkg::word_t     ex_epc;
	logic                     ex_ack;
	logic                     wb_valid;
	cpu_types_pkg::reg_addr_t wb_reg_addr;
	cpu_types_pkg::word_t     wb_reg_data;
	logic                     exc_jmp_flag;
	cpu_types_pkg::word_t     exc_jmp_dest;
	cpu_types_pkg::int_mask_t int_req;
	cpu_types_pkg::int_mask_t int_ack;

	entry_t entries[$];
	string  names[$];

	int errors;
	int timeouts;
	int wb_count;
	int jmp_count;

	cpu_types_pkg::reg_addr_t seen_wb_reg;
	cpu_types_pkg::word_t     seen_wb_data;
	cpu_types_pkg::word_t     seen_jmp_dest;
	cpu_types_pkg::int_mask_t seen_int_ack;

	mem_subsys_top u_mem_subsys_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic add(input string name, input cpu_types_pkg::mem_opt_t op,
		input cpu_types_pkg::word_t addr, input cpu_types_pkg::word_t val,
		input cpu_types_pkg::reg_addr_t rd, input cpu_types_pkg::exc_code_t code,
		input cpu_types_pkg::word_t epc, input cpu_types_pkg::int_mask_t irq,
		input logic [1:0] kind, input cpu_types_pkg::word_t exp_data,
		input cpu_types_pkg::int_mask_t exp_ip);
		entry_t e;
		e = '{op, addr, val, rd, code, epc, irq, kind, exp_data, exp_ip};
		entries.push_back(e);
		names.push_back(name);
	endtask

	// Expected cause is ip << 8 | code << 2
	// Indices 8, 12, 13 and 14 are badvaddr, status, cause and epc
	task automatic build_table();
		add("status_reset", CRD, 32'd12, 32'h0, 5'd1, NOEXC, 32'h0, 8'h00, X_WB, 32'h0, 8'h00);
		add("alu_pass", ALU, 32'h0, 32'h12345678, 5'd3, NOEXC, 32'h0, 8'h00, X_WB, 32'h12345678, 8'h00);
		add("alu_r0", ALU, 32'h0, 32'hcafe0000, 5'd0, NOEXC, 32'h0, 8'h00, X_QUIET, 32'h0, 8'h00);
		add("st_010", ST, 32'h10, 32'ha5a50010, 5'd0, NOEXC, 32'h0, 8'h00, X_QUIET, 32'h0, 8'h00);
		add("st_020", ST, 32'h20, 32'h5a5a0020, 5'd0, NOEXC, 32'h0, 8'h00, X_QUIET, 32'h0, 8'h00);
		add("st_3fc", ST, 32'h3fc, 32'h0ff003fc, 5'd0, NOEXC, 32'h0, 8'h00, X_QUIET, 32'h0, 8'h00);
		add("ld_010", LD, 32'h10, 32'h0, 5'd4, NOEXC, 32'h0, 8'h00, X_WB, 32'ha5a50010, 8'h00);
		add("ld_020", LD, 32'h20, 32'h0, 5'd5, NOEXC, 32'h0, 8'h00, X_WB, 32'h5a5a0020, 8'h00);
		add("ld_3fc", LD, 32'h3fc, 32'h0, 5'd6, NOEXC, 32'h0, 8'h00, X_WB, 32'h0ff003fc, 8'h00);
		add("status_wr", CWR, 32'd12, 32'h0000aa00, 5'd0, NOEXC, 32'h0, 8'h00, X_QUIET, 32'h0, 8'h00);
		add("status_rd", CRD, 32'd12, 32'h0, 5'd7, NOEXC, 32'h0, 8'h00, X_WB, 32'h0000aa00, 8'h00);
		add("unlisted_rd", CRD, 32'd5, 32'h0, 5'd8, NOEXC, 32'h0, 8'h00, X_WB, 32'h0, 8'h00);
		add("ld_misaligned", LD, 32'h22, 32'h0, 5'd9, NOEXC, 32'h400, 8'h00, X_EXC, 32'h0, 8'h00);
		add("cause_adel", CRD, 32'd13, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h10, 8'h00);
		add("badvaddr_adel", CRD, 32'd8, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h22, 8'h00);
		add("epc_adel", CRD, 32'd14, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h400, 8'h00);
		add("st_misaligned", ST, 32'h11, 32'hdeadbeef, 5'd0, NOEXC, 32'h404, 8'h00, X_EXC, 32'h0, 8'h00);
		add("cause_ades", CRD, 32'd13, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h14, 8'h00);
		add("badvaddr_ades", CRD, 32'd8, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h11, 8'h00);
		add("ld_after_ades", LD, 32'h10, 32'h0, 5'd4, NOEXC, 32'h0, 8'h00, X_WB, 32'ha5a50010, 8'h00);
		add("ld_out_range", LD, 32'h400, 32'h0, 5'd9, NOEXC, 32'h408, 8'h00, X_EXC, 32'h0, 8'h00);
		add("cause_dbe", CRD, 32'd13, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h1c, 8'h00);
		add("badvaddr_dbe", CRD, 32'd8, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h400, 8'h00);
		add("st_out_range", ST, 32'h410, 32'hbad00410, 5'd0, NOEXC, 32'h40c, 8'h00, X_EXC, 32'h0, 8'h00);
		add("ld_after_dbe", LD, 32'h10, 32'h0, 5'd4, NOEXC, 32'h0, 8'h00, X_WB, 32'ha5a50010, 8'h00);
		// IE set, EXL clear, IM line 2 enabled
		add("status_ie", CWR, 32'd12, 32'h00000401, 5'd0, NOEXC, 32'h0, 8'h00, X_QUIET, 32'h0, 8'h00);
		add("sys_over_int", ALU, 32'h0, 32'h1, 5'd11, SYS, 32'h500, 8'h04, X_EXC, 32'h0, 8'h00);
		add("cause_sys", CRD, 32'd13, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h20, 8'h00);
		add("epc_sys", CRD, 32'd14, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h500, 8'h00);
		add("int_exl_set", ALU, 32'h0, 32'h77, 5'd12, NOEXC, 32'h0, 8'h04, X_WB, 32'h77, 8'h00);
		add("status_exl_clr", CWR, 32'd12, 32'h00000401, 5'd0, NOEXC, 32'h0, 8'h00, X_QUIET, 32'h0, 8'h00);
		add("int_taken", ALU, 32'h0, 32'h88, 5'd13, NOEXC, 32'h600, 8'h05, X_EXC, 32'h0, 8'h04);
		add("cause_int", CRD, 32'd13, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h400, 8'h00);
		add("epc_int", CRD, 32'd14, 32'h0, 5'd10, NOEXC, 32'h0, 8'h00, X_WB, 32'h600, 8'h00);
		add("status_im_clr", CWR, 32'd12, 32'h00000001, 5'd0, NOEXC, 32'h0, 8'h00, X_QUIET, 32'h0, 8'h00);
		add("int_masked", ALU, 32'h0, 32'h99, 5'd14, NOEXC, 32'h0, 8'hff, X_WB, 32'h99, 8'h00);
	endtask

	// Advance one clock and sample outputs settled after the edge
	task automatic step();
		@(posedge clk);
		#1;
		if (wb_valid) begin
			wb_count++;
			seen_wb_reg  = wb_reg_addr;
			seen_wb_data = wb_reg_data;
		end
		if (exc_jmp_flag) begin
			jmp_count++;
			seen_jmp_dest = exc_jmp_dest;
		end
		seen_int_ack |= int_ack;
	endtask

	task automatic wait_for_ack(input logic level, input string name);
		int cycles;
		cycles = 0;
		while (ex_ack !== level && cycles < TIMEOUT_CYCLES) begin
			step();
			cycles++;
		end
		if (ex_ack !== level) begin
			$display("Timeout in %s: ex_ack did not become %0b within %0d cycles",
				name, level, TIMEOUT_CYCLES);
			timeouts++;
		end
	endtask

	task automatic check_val(input string name, input string what,
		input cpu_types_pkg::word_t exp, input cpu_types_pkg::word_t act);
		assert (act === exp) else begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic run_entry(input int i);
		entry_t e;
		int     hold;
		e = entries[i];
		ex_mem_opt  = e.op;
		ex_mem_addr = e.addr;
		if (e.op == ALU) begin
			ex_alu_result = e.val;
			ex_mem_data   = ~e.val; // Other source differs so a swap shows up
		end else begin
			ex_mem_data   = e.val;
			ex_alu_result = ~e.val;
		end
		ex_wb_reg    = e.rd;
		ex_exc_code  = e.code;
		ex_epc       = e.epc;
		int_req      = e.irq;
		wb_count     = 0;
		jmp_count    = 0;
		seen_int_ack = '0;
		ex_req       = 1'b1;
		wait_for_ack(1'b1, names[i]);
		if (timeouts != 0)
			return;
		hold = int'($urandom % 4);
		repeat (hold) step();
		ex_req = 1'b0;
		wait_for_ack(1'b0, names[i]);
		if (timeouts != 0)
			return;
		case (e.kind)
			X_WB: begin
				check_val(names[i], "write-back count", 1, wb_count);
				check_val(names[i], "jump count", 0, jmp_count);
				check_val(names[i], "write-back register", 32'(e.rd), 32'(seen_wb_reg));
				check_val(names[i], "write-back data", e.exp_data, seen_wb_data);
			end
			X_EXC: begin
				check_val(names[i], "jump count", 1, jmp_count);
				check_val(names[i], "write-back count", 0, wb_count);
				check_val(names[i], "jump destination", 32'h80000180, seen_jmp_dest);
			end
			default: begin
				check_val(names[i], "write-back count", 0, wb_count);
				check_val(names[i], "jump count", 0, jmp_count);
			end
		endcase
		check_val(names[i], "int_ack lines", 32'(e.exp_ip), 32'(seen_int_ack));
	endtask

	initial begin
		void'($urandom(SEED));
		rst           = 1'b1;
		ex_req        = 1'b0;
		ex_mem_opt    = ALU;
		ex_mem_addr   = '0;
		ex_mem_data   = '0;
		ex_alu_result = '0;
		ex_wb_reg     = '0;
		ex_exc_code   = NOEXC;
		ex_epc        = '0;
		int_req       = '0;
		errors        = 0;
		timeouts      = 0;
		build_table();
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		check_val("reset", "ex_ack", 0, 32'(ex_ack));
		check_val("reset", "wb_valid", 0, 32'(wb_valid));
		check_val("reset", "exc_jmp_flag", 0, 32'(exc_jmp_flag));
		check_val("reset", "int_ack", 0, 32'(int_ack));
		foreach (entries[i]) begin
			if (timeouts == 0)
				run_entry(i);
		end
		repeat (4) @(posedge clk); // Let the bound assertions see the last cycles
		$display("Summary: %0d entries, %0d check errors, %0d timeouts, %0d assertion failures",
			entries.size(), errors, timeouts, u_mem_subsys_top.u_chk.fail_count);
		if (errors == 0 && timeouts == 0 && u_mem_subsys_top.u_chk.fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- project.f
hdl/cpu_types_pkg.sv
hdl/cp0_pkg.sv
hdl/mem_bus_if.sv
hdl/stage_mem.sv
hdl/cp0_regs.sv
hdl/data_mem.sv
hdl/mem_subsys_top.sv
dv/mem_subsys_chk.sv
dv/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it

LOG=sim.log
FAIL_TEXT="Something failed"

verilator --binary --timing --assert -f project.f \
	--top-module tb_mem_subsys --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Checker errors must not stop the run before the summary
./obj_dir/sim_tb +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "$FAIL_TEXT" "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi

echo "Simulation passed, see $LOG"
exit 0
